//--- common/beam_sort_macros.svh
// ---------------------------------------------------------
// Beam sort constants: block geometry, lanes, table, credits
// ---------------------------------------------------------
`ifndef BEAM_SORT_MACROS_SVH
`define BEAM_SORT_MACROS_SVH

// Elements per block
`define BS_COL        64

// Width of one beam power
`define BS_IW         32

// Ranking lanes working in parallel
`define BS_LANES      4

// Strongest beams kept per block
`define BS_TOP        16

// Rows in the beam index table
`define BS_RBG_DEPTH  16

// Readout credits after reset
`define BS_CREDITS    4

`endif

//--- common/beam_sort_pkg.sv
// ---------------------------------------------------------
// Beam sort shared types: powers, indices and bundled rows
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

package beam_sort_pkg;

    // Scalars
    typedef logic [`BS_IW-1:0] power_t;
    typedef logic [7:0]        beam_idx_t;
    typedef logic [3:0]        rbg_t;

    // One block of powers, element 0 in the low word
    typedef power_t [`BS_COL-1:0] block_t;

    // Score of every element, same ordering as block_t
    typedef beam_idx_t [`BS_COL-1:0] score_vec_t;

    // ---------------------------------------------------------
    // Bundles
    // ---------------------------------------------------------

    // Block in sorted order plus the original index per position
    typedef struct packed {
        block_t                    data;
        beam_idx_t [`BS_COL-1:0]   idx;
    } sorted_block_t;

    // One readout row of the index table
    typedef struct packed {
        rbg_t                      rbg;
        logic                      sop;
        beam_idx_t [`BS_TOP-1:0]   idx;
    } index_row_t;

endpackage

`default_nettype wire

//--- hw/rank/rank_lane.sv
// ---------------------------------------------------------
// Rank lane: scores one element against the whole block
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module rank_lane (
    input  wire                          i_clk,
    input  wire beam_sort_pkg::block_t    i_block,
    input  wire beam_sort_pkg::beam_idx_t i_index,
    output beam_sort_pkg::beam_idx_t      o_score
);
    import beam_sort_pkg::*;

    localparam int SEL_W = $clog2(`BS_COL);

    power_t    self_pwr;
    beam_idx_t score_c;

    // Element under test
    assign self_pwr = i_block[i_index[SEL_W-1:0]];

    // ---------------------------------------------------------
    // Score rule
    // ---------------------------------------------------------

    // Count strictly larger elements, plus equal ones at a lower index.
    // The element itself is equal but never at a lower index, so it
    // does not count against itself
    always_comb begin
        score_c = '0;
        for (int j = 0; j < `BS_COL; j++) begin
            if (i_block[j] > self_pwr) begin
                score_c = score_c + 1'b1;
            end else if ((i_block[j] == self_pwr) && (beam_idx_t'(j) < i_index)) begin
                score_c = score_c + 1'b1;
            end
        end
    end

    // Registered result, one cycle after the index is presented
    always_ff @(posedge i_clk) begin
        o_score <= score_c;
    end

endmodule

`default_nettype wire

//--- hw/rank/rank_engine.sv
// ---------------------------------------------------------
// Rank engine: captures a block and scores it four lanes wide
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module rank_engine (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire beam_sort_pkg::block_t    i_data,
    input  wire                          i_valid,
    output logic                         o_ready,
    output beam_sort_pkg::block_t         o_block,
    output beam_sort_pkg::score_vec_t     o_scores,
    output logic                         o_scores_done
);
    import beam_sort_pkg::*;

    localparam int GROUPS = `BS_COL / `BS_LANES;
    localparam int GRP_W  = $clog2(GROUPS);

    logic                       ready_q;
    logic                       accept;
    block_t                     block_q;
    logic                       run_q;
    logic [GRP_W-1:0]           grp_q;
    logic                       load_q;
    logic [GRP_W-1:0]           load_grp_q;
    score_vec_t                 scores_q;
    logic                       done_q;
    beam_idx_t [`BS_LANES-1:0]  lane_idx;
    beam_idx_t [`BS_LANES-1:0]  lane_score;

    assign accept = i_valid & ready_q;

    // ---------------------------------------------------------
    // Handshake and group sequencing
    // ---------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ready_q    <= 1'b1;
            run_q      <= 1'b0;
            grp_q      <= '0;
            load_q     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            // Busy until the scatter stage has taken the scores
            if (accept) begin
                ready_q <= 1'b0;
            end else if (done_q) begin
                ready_q <= 1'b1;
            end

            if (accept) begin
                run_q <= 1'b1;
                grp_q <= '0;
            end else if (run_q) begin
                grp_q <= grp_q + 1'b1;
                if (grp_q == GRP_W'(GROUPS - 1)) begin
                    run_q <= 1'b0;
                end
            end

            // Lane results trail the presented group by one cycle
            load_q <= run_q;
            done_q <= load_q && (load_grp_q == GRP_W'(GROUPS - 1));
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            block_q <= i_data;
        end
        load_grp_q <= grp_q;
    end

    // ---------------------------------------------------------
    // Lanes
    // ---------------------------------------------------------
    for (genvar k = 0; k < `BS_LANES; k++) begin : g_lane
        assign lane_idx[k] = beam_idx_t'(int'(grp_q) * `BS_LANES + k);

        rank_lane u_rank_lane (
            .i_clk   (i_clk),
            .i_block (block_q),
            .i_index (lane_idx[k]),
            .o_score (lane_score[k])
        );
    end

    // Collect the scores of the group that just landed
    always_ff @(posedge i_clk) begin
        if (load_q) begin
            for (int k = 0; k < `BS_LANES; k++) begin
                scores_q[int'(load_grp_q) * `BS_LANES + k] <= lane_score[k];
            end
        end
    end

    assign o_ready       = ready_q;
    assign o_block       = block_q;
    assign o_scores      = scores_q;
    assign o_scores_done = done_q;

endmodule

`default_nettype wire

//--- hw/sort/sort_scatter.sv
// ---------------------------------------------------------
// Sort scatter: reorders a block by score, extracts the top 16
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module sort_scatter (
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire beam_sort_pkg::block_t                i_block,
    input  wire beam_sort_pkg::score_vec_t            i_scores,
    input  wire                                      i_scores_done,
    output beam_sort_pkg::sorted_block_t              o_sorted,
    output logic                                     o_sorted_valid,
    output beam_sort_pkg::beam_idx_t [`BS_TOP-1:0]    o_top,
    output logic                                     o_row_write
);
    import beam_sort_pkg::*;

    localparam int SEL_W = $clog2(`BS_COL);

    sorted_block_t sorted_q;
    logic          valid_q;

    // ---------------------------------------------------------
    // Scatter
    // ---------------------------------------------------------

    // Scores form a permutation, so every position gets exactly one write
    always_ff @(posedge i_clk) begin
        if (i_scores_done) begin
            for (int i = 0; i < `BS_COL; i++) begin
                sorted_q.data[i_scores[i][SEL_W-1:0]] <= i_block[i];
                sorted_q.idx[i_scores[i][SEL_W-1:0]]  <= beam_idx_t'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_scores_done;
        end
    end

    // ---------------------------------------------------------
    // Outputs
    // ---------------------------------------------------------
    assign o_sorted       = sorted_q;
    assign o_sorted_valid = valid_q;

    // Strongest beams sit at the lowest sorted positions
    assign o_top          = sorted_q.idx[`BS_TOP-1:0];
    assign o_row_write    = valid_q;

endmodule

`default_nettype wire

//--- hw/sort/beam_index_table.sv
// ---------------------------------------------------------
// Beam index table: top-16 rows per RBG, credit-paced readout
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module beam_index_table (
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire beam_sort_pkg::beam_idx_t [`BS_TOP-1:0] i_top,
    input  wire                                      i_row_write,
    input  wire                                      i_read_start,
    input  wire beam_sort_pkg::rbg_t                  i_rbg_max,
    input  wire                                      i_credit,
    output beam_sort_pkg::index_row_t                 o_row,
    output logic                                     o_row_valid
);
    import beam_sort_pkg::*;

    localparam int CREDIT_W = $clog2(`BS_CREDITS + 1);

    beam_idx_t [`BS_TOP-1:0]  mem [`BS_RBG_DEPTH];
    rbg_t                     wr_rbg_q;

    logic                     active_q;
    logic                     first_q;
    rbg_t                     rd_rbg_q;
    logic [CREDIT_W-1:0]      credit_q;
    logic [CREDIT_W-1:0]      credit_next;
    logic                     issue;

    index_row_t               row_q;
    logic                     row_valid_q;

    // ---------------------------------------------------------
    // Write side
    // ---------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_row_write) begin
            mem[wr_rbg_q] <= i_top;
        end
    end

    // RBG counter wraps with the table depth
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_rbg_q <= '0;
        end else if (i_row_write) begin
            wr_rbg_q <= wr_rbg_q + 1'b1;
        end
    end

    // ---------------------------------------------------------
    // Read pass and credits
    // ---------------------------------------------------------
    assign issue = active_q && (credit_q != '0);

    // Return saturates at the initial credit count
    always_comb begin
        credit_next = credit_q;
        if (issue) begin
            credit_next = credit_next - 1'b1;
        end
        if (i_credit && (credit_next != CREDIT_W'(`BS_CREDITS))) begin
            credit_next = credit_next + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active_q    <= 1'b0;
            first_q     <= 1'b0;
            rd_rbg_q    <= '0;
            credit_q    <= CREDIT_W'(`BS_CREDITS);
            row_valid_q <= 1'b0;
        end else begin
            credit_q    <= credit_next;
            row_valid_q <= issue;

            // Start is ignored while a pass is running
            if (!active_q) begin
                if (i_read_start) begin
                    active_q <= 1'b1;
                    first_q  <= 1'b1;
                    rd_rbg_q <= '0;
                end
            end else if (issue) begin
                first_q  <= 1'b0;
                rd_rbg_q <= rd_rbg_q + 1'b1;
                if (rd_rbg_q == i_rbg_max) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // Registered table read
    always_ff @(posedge i_clk) begin
        if (issue) begin
            row_q.rbg <= rd_rbg_q;
            row_q.sop <= first_q;
            row_q.idx <= mem[rd_rbg_q];
        end
    end

    assign o_row       = row_q;
    assign o_row_valid = row_valid_q;

endmodule

`default_nettype wire

//--- hw/beam_sort_top.sv
// ---------------------------------------------------------
// Beam sort top: rank engine, scatter stage and index table
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module beam_sort_top (
    input  wire                          i_clk,
    input  wire                          i_reset,

    // Block input
    input  wire beam_sort_pkg::block_t    i_data,
    input  wire                          i_valid,
    output logic                         o_ready,

    // Sorted block output
    output beam_sort_pkg::sorted_block_t  o_sorted,
    output logic                         o_sorted_valid,

    // Index table readout
    input  wire                          i_read_start,
    input  wire beam_sort_pkg::rbg_t      i_rbg_max,
    input  wire                          i_credit,
    output beam_sort_pkg::index_row_t     o_row,
    output logic                         o_row_valid
);
    import beam_sort_pkg::*;

    block_t                    block;
    score_vec_t                scores;
    logic                      scores_done;
    beam_idx_t [`BS_TOP-1:0]   top;
    logic                      row_write;

    rank_engine u_rank_engine (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_data        (i_data),
        .i_valid       (i_valid),
        .o_ready       (o_ready),
        .o_block       (block),
        .o_scores      (scores),
        .o_scores_done (scores_done)
    );

    sort_scatter u_sort_scatter (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_block        (block),
        .i_scores       (scores),
        .i_scores_done  (scores_done),
        .o_sorted       (o_sorted),
        .o_sorted_valid (o_sorted_valid),
        .o_top          (top),
        .o_row_write    (row_write)
    );

    beam_index_table u_beam_index_table (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_top        (top),
        .i_row_write  (row_write),
        .i_read_start (i_read_start),
        .i_rbg_max    (i_rbg_max),
        .i_credit     (i_credit),
        .o_row        (o_row),
        .o_row_valid  (o_row_valid)
    );

endmodule

`default_nettype wire

//--- tb/beam_sort_chk.sv
// ---------------------------------------------------------
// Beam sort checker: handshake, latency, credit and reset rules
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module beam_sort_chk (
    input wire                            i_clk,
    input wire                            i_reset,
    input wire                            i_valid,
    input wire                            i_ready,
    input wire beam_sort_pkg::block_t     i_block,
    input wire                            i_sorted_valid,
    input wire                            i_row_valid,
    input wire beam_sort_pkg::index_row_t i_row,
    input wire                            i_credit
);
    import beam_sort_pkg::*;

    logic        busy_q;
    logic [4:0]  age_q;
    logic [3:0]  owed_q;
    int unsigned fail_count = 0;

    // Cycles since the last accepted block
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy_q <= 1'b0;
            age_q  <= '0;
        end else if (i_valid && i_ready) begin
            busy_q <= 1'b1;
            age_q  <= '0;
        end else if (busy_q) begin
            age_q <= age_q + 5'd1;
            if (i_sorted_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Rows seen on the stream that still hold a credit
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owed_q <= '0;
        end else if (i_row_valid && !i_credit) begin
            owed_q <= owed_q + 4'd1;
        end else if (!i_row_valid && i_credit && (owed_q != '0)) begin
            owed_q <= owed_q - 4'd1;
        end
    end

    // ---------------------------------------------------------
    // Properties
    // ---------------------------------------------------------
    assert property (@(posedge i_clk) i_reset |=> (i_ready && !i_sorted_valid && !i_row_valid))
        else begin $error("outputs not idle after reset"); fail_count++; end

    assert property (@(posedge i_clk) disable iff (i_reset)
        i_sorted_valid |-> (busy_q && (age_q == 5'd18)))
        else begin $error("o_sorted_valid outside its slot"); fail_count++; end

    assert property (@(posedge i_clk) disable iff (i_reset)
        (busy_q && (age_q == 5'd18)) |-> i_sorted_valid)
        else begin $error("o_sorted_valid missing 18 cycles after acceptance"); fail_count++; end

    assert property (@(posedge i_clk) disable iff (i_reset)
        (busy_q && !i_sorted_valid) |-> !i_ready)
        else begin $error("o_ready high while a block is in flight"); fail_count++; end

    // A block offered while busy must leave the captured block alone
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_valid && !i_ready) |=> $stable(i_block))
        else begin $error("block captured while o_ready was low"); fail_count++; end

    assert property (@(posedge i_clk) disable iff (i_reset)
        owed_q <= 4'(`BS_CREDITS))
        else begin $error("more rows outstanding than credits"); fail_count++; end

    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_row_valid && (i_row.rbg == '0)) |-> i_row.sop)
        else begin $error("row 0 without start flag"); fail_count++; end

endmodule

bind beam_sort_top beam_sort_chk u_chk (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_valid        (i_valid),
    .i_ready        (o_ready),
    .i_block        (block),
    .i_sorted_valid (o_sorted_valid),
    .i_row_valid    (o_row_valid),
    .i_row          (o_row),
    .i_credit       (i_credit)
);

`default_nettype wire

//--- tb/beam_sort_tb.sv
// ---------------------------------------------------------
// Beam sort testbench with LCG blocks and a score model
// that checks the sorted output and the readout stream
// ---------------------------------------------------------
`default_nettype none

`include "beam_sort_macros.svh"

module beam_sort_tb;
    import beam_sort_pkg::*;

    typedef beam_idx_t [`BS_TOP-1:0] top_t;

    localparam int N_BLOCKS = 6;
    localparam int N_ROWS   = 2 * N_BLOCKS;
    localparam int LIMIT    = 2 * (40 * N_BLOCKS + 8 * N_ROWS);

    logic          clk = 1'b0;
    logic          reset;
    block_t        data;
    logic          valid;
    logic          read_start;
    rbg_t          rbg_max;
    logic          credit;
    logic          ready;
    sorted_block_t sorted;
    logic          sorted_valid;
    index_row_t    row;
    logic          row_valid;

    logic [31:0]   rng = 32'haeba_fb14;
    top_t          exp_rows[$];
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    always #4 clk = ~clk;

    beam_sort_top u_beam_sort_top (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_data         (data),
        .i_valid        (valid),
        .o_ready        (ready),
        .o_sorted       (sorted),
        .o_sorted_valid (sorted_valid),
        .i_read_start   (read_start),
        .i_rbg_max      (rbg_max),
        .i_credit       (credit),
        .o_row          (row),
        .o_row_valid    (row_valid)
    );

    function automatic power_t next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Block modes are full range (0), four-bit from the high bits (1) and all equal (2)
    function automatic block_t make_block(input int mode);
        block_t b;
        power_t fill;
        fill = next_rand();
        for (int i = 0; i < `BS_COL; i++) begin
            case (mode)
                1:       b[i] = next_rand() >> 28;
                2:       b[i] = fill;
                default: b[i] = next_rand();
            endcase
        end
        return b;
    endfunction

    task automatic show_mismatch(input string name, input string what,
                                 input logic [127:0] exp, input logic [127:0] act);
        $display("error %s: %s expected %0h actual %0h", name, what, exp, act);
        errors++;
    endtask

    task automatic flag_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - mark);
        end
    endtask

    // ---------------------------------------------------------
    // Score model and sorted block checks
    // ---------------------------------------------------------
    task automatic check_sorted(input string name, input block_t blk, input sorted_block_t s);
        beam_idx_t exp_idx [`BS_COL];
        bit        seen [`BS_COL];
        int        sc;
        top_t      top;
        for (int i = 0; i < `BS_COL; i++) begin
            sc = 0;
            for (int j = 0; j < `BS_COL; j++) begin
                if ((blk[j] > blk[i]) || ((blk[j] == blk[i]) && (j < i))) begin
                    sc++;
                end
            end
            exp_idx[sc] = beam_idx_t'(i);
            seen[i] = 1'b0;
        end
        for (int p = 0; p < `BS_COL; p++) begin
            assert (s.idx[p] == exp_idx[p])
                else show_mismatch(name, $sformatf("index at %0d", p), exp_idx[p], s.idx[p]);
            assert (s.data[p] == blk[exp_idx[p]])
                else show_mismatch(name, $sformatf("data at %0d", p),
                                   blk[exp_idx[p]], s.data[p]);
            if (p > 0) begin
                assert (s.data[p-1] >= s.data[p])
                    else flag_failure($sformatf("%s: data increases at position %0d", name, p));
                if (s.data[p-1] == s.data[p]) begin
                    assert (s.idx[p-1] < s.idx[p])
                        else flag_failure($sformatf("%s: tie out of index order at %0d", name, p));
                end
            end
            if (s.idx[p] < `BS_COL) begin
                assert (!seen[s.idx[p]])
                    else flag_failure($sformatf("%s: index %0d appears twice", name, s.idx[p]));
                seen[s.idx[p]] = 1'b1;
            end else begin
                flag_failure($sformatf("%s: index %0d out of range", name, s.idx[p]));
            end
        end
        for (int k = 0; k < `BS_TOP; k++) begin
            top[k] = exp_idx[k];
        end
        exp_rows.push_back(top);
    endtask

    // Offer a block and keep offering other data while busy before checking the result
    task automatic run_block(input string name, input block_t blk);
        int lat;
        int wait_cyc;
        @(posedge clk);
        data  <= blk;
        valid <= 1'b1;
        wait_cyc = 0;
        @(negedge clk);
        while (!ready && (wait_cyc < 40)) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (!ready) begin
            flag_failure({name, ": o_ready never came high"});
            @(posedge clk);
            valid <= 1'b0;
            return;
        end
        @(posedge clk);
        data <= make_block(0);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat < 10) begin
                data <= make_block(0);
            end else begin
                valid <= 1'b0;
            end
            @(negedge clk);
        end while (!sorted_valid && (lat < 40));
        if (!sorted_valid) begin
            flag_failure({name, ": o_sorted_valid never arrived"});
        end else begin
            assert (lat == 18) else show_mismatch(name, "latency", 18, lat);
            check_sorted(name, blk, sorted);
        end
    endtask

    // ---------------------------------------------------------
    // Readout pass with credits returned per row or withheld
    // ---------------------------------------------------------
    task automatic read_pass(input string name, input bit withhold);
        int got;
        int given;
        int returned;
        int quiet;
        int cyc;
        bit pulse;
        got = 0;
        given = 0;
        returned = 0;
        quiet = 0;
        cyc = 0;
        pulse = 1'b0;
        @(posedge clk);
        read_start <= 1'b1;
        rbg_max    <= rbg_t'(exp_rows.size() - 1);
        while ((got < exp_rows.size()) && (cyc < 8 * N_ROWS)) begin
            @(posedge clk);
            read_start <= 1'b0;
            credit     <= pulse;
            if (pulse) begin
                returned++;
            end
            @(negedge clk);
            cyc++;
            pulse = 1'b0;
            if (row_valid) begin
                assert (row.rbg == rbg_t'(got))
                    else show_mismatch(name, "row number", got, row.rbg);
                assert (row.sop == (got == 0))
                    else show_mismatch(name, "start flag", got == 0, row.sop);
                assert (row.idx == exp_rows[got])
                    else show_mismatch(name, $sformatf("row %0d indices", got),
                                       exp_rows[got], row.idx);
                got++;
                quiet = 0;
                pulse = !withhold;
            end else begin
                quiet++;
            end
            // Release one more row once the stream has gone quiet
            if (withhold && (quiet == 8)) begin
                assert (got == `BS_CREDITS + given)
                    else show_mismatch(name, "rows released", `BS_CREDITS + given, got);
                given++;
                pulse = 1'b1;
                quiet = 0;
            end
        end
        if (got < exp_rows.size()) begin
            flag_failure($sformatf("%s: pass stopped after %0d rows", name, got));
        end
        repeat (got - returned + 4) begin
            @(posedge clk);
            credit <= (returned < got);
            if (returned < got) begin
                returned++;
            end
            @(negedge clk);
            assert (!row_valid) else flag_failure({name, ": row seen after the end of the pass"});
        end
    endtask

    initial begin
        int mark;
        reset      = 1'b1;
        data       = '0;
        valid      = 1'b0;
        read_start = 1'b0;
        rbg_max    = '0;
        credit     = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        mark = errors;
        repeat (2) run_block("random_blocks", make_block(0));
        end_test("random_blocks", mark);

        mark = errors;
        run_block("tie_blocks", make_block(2));
        repeat (3) run_block("tie_blocks", make_block(1));
        end_test("tie_blocks", mark);

        mark = errors;
        read_pass("readout_in_order", 1'b0);
        end_test("readout_in_order", mark);

        mark = errors;
        read_pass("credit_backpressure", 1'b1);
        end_test("credit_backpressure", mark);

        repeat (4) @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors,
                 u_beam_sort_top.u_chk.fail_count);
        if ((errors == 0) && (tests_failed == 0) && (u_beam_sort_top.u_chk.fail_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the block and row counts
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog expired after %0d cycles", LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/beam_sort_pkg.sv
hw/rank/rank_lane.sv
hw/rank/rank_engine.sv
hw/sort/sort_scatter.sv
hw/sort/beam_index_table.sv
hw/beam_sort_top.sv
tb/beam_sort_chk.sv
tb/beam_sort_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the beam sort testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module beam_sort_tb \
    -f vlog.f \
    -o beam_sort_sim

./obj_dir/beam_sort_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
